// File: all.f
cnn_geom_pkg.sv
cnn_data_pkg.sv
cnn_ctrl.sv
cnn_counters.sv
kernel_store.sv
line_window.sv
binary_conv.sv
cnn_top.sv
tb_cnn.sv

// File: binary_conv.sv
`timescale 1ns/100ps
`default_nettype none

module binary_conv (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire cnn_data_pkg::tap_row_t taps [cnn_geom_pkg::k_size],
    input  wire                       taps_valid,
    input  wire cnn_data_pkg::kernel_t  kernels [cnn_geom_pkg::n_kernels],
    output logic                      result_tvalid,
    output cnn_data_pkg::result_t     result_tdata [cnn_geom_pkg::n_kernels]
);

    cnn_data_pkg::acc_t row_acc [cnn_geom_pkg::n_kernels][cnn_geom_pkg::k_size];
    cnn_data_pkg::acc_t total   [cnn_geom_pkg::n_kernels];
    logic               row_valid;

    // weight 1 adds the pixel, weight 0 subtracts it
    function automatic cnn_data_pkg::acc_t row_sum(
        input cnn_data_pkg::tap_row_t       row,
        input logic [cnn_geom_pkg::k_size-1:0] w
    );
        cnn_data_pkg::acc_t s;
        s = '0;
        for (int c = 0; c < cnn_geom_pkg::k_size; c++) begin
            if (w[c])
                s = s + cnn_data_pkg::acc_t'(row[c]);
            else
                s = s - cnn_data_pkg::acc_t'(row[c]);
        end
        return s;
    endfunction

    always_ff @(posedge clk) begin
        for (int k = 0; k < cnn_geom_pkg::n_kernels; k++) begin
            for (int r = 0; r < cnn_geom_pkg::k_size; r++) begin
                row_acc[k][r] <= row_sum(taps[r],
                    kernels[k][r*cnn_geom_pkg::k_size +: cnn_geom_pkg::k_size]);
            end
        end
    end

    always_comb begin
        for (int k = 0; k < cnn_geom_pkg::n_kernels; k++) begin
            total[k] = '0;
            for (int r = 0; r < cnn_geom_pkg::k_size; r++) begin
                total[k] = total[k] + row_acc[k][r];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < cnn_geom_pkg::n_kernels; k++) begin
            result_tdata[k] <= (total[k] < 0) ? '0 : total[k];   // relu
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row_valid     <= 1'b0;
            result_tvalid <= 1'b0;
        end else begin
            row_valid     <= taps_valid;
            result_tvalid <= row_valid;
        end
    end

endmodule

`default_nettype wire

// File: cnn_counters.sv
`timescale 1ns/100ps
`default_nettype none

module cnn_counters (
    input  wire  clk,
    input  wire  rstn,
    input  wire  counter_clr,
    input  wire  weight_fire,
    input  wire  pixel_fire,
    input  wire  load_image,
    output logic weights_full,
    output logic image_last,
    output logic window_ok,
    output logic drain_done
);

    logic [cnn_geom_pkg::wcnt_w-1:0]             wcnt;
    logic [cnn_geom_pkg::col_w-1:0]              col;
    logic [cnn_geom_pkg::row_w-1:0]              row;
    logic [$clog2(cnn_geom_pkg::pipe_depth)-1:0] dcnt;
    logic                                        draining;
    logic                                        col_end;
    logic                                        pix_en;

    assign pix_en  = pixel_fire & load_image;
    assign col_end = (col == cnn_geom_pkg::col_w'(cnn_geom_pkg::img_w - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wcnt     <= '0;
            col      <= '0;
            row      <= '0;
            dcnt     <= '0;
            draining <= 1'b0;
        end else if (counter_clr) begin
            wcnt     <= '0;
            col      <= '0;
            row      <= '0;
            dcnt     <= '0;
            draining <= 1'b0;
        end else begin
            if (weight_fire)
                wcnt <= wcnt + 1'b1;
            if (pix_en) begin
                col <= col_end ? '0 : col + 1'b1;   // row-major scan
                if (col_end)
                    row <= row + 1'b1;
            end
            if (image_last)
                draining <= 1'b1;
            else if (drain_done)
                draining <= 1'b0;
            if (draining)
                dcnt <= dcnt + 1'b1;
        end
    end

    // flags mark the transfer that is being accepted this cycle
    assign weights_full = weight_fire &
        (wcnt == cnn_geom_pkg::wcnt_w'(cnn_geom_pkg::n_weight_bits - 1));
    assign image_last = pix_en & col_end &
        (row == cnn_geom_pkg::row_w'(cnn_geom_pkg::img_h - 1));
    assign window_ok = pix_en &
        (col >= cnn_geom_pkg::col_w'(cnn_geom_pkg::k_size - 1)) &
        (row >= cnn_geom_pkg::row_w'(cnn_geom_pkg::k_size - 1));

    // last result leaves the add tree as this goes high
    assign drain_done = draining &
        (dcnt == $bits(dcnt)'(cnn_geom_pkg::pipe_depth - 1));

endmodule

`default_nettype wire

// File: cnn_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cnn_ctrl (
    input  wire  clk,
    input  wire  rstn,
    input  wire  start_cnn,
    input  wire  weights_full,
    input  wire  image_last,
    input  wire  drain_done,
    output logic weight_tready,
    output logic image_tready,
    output logic load_weights,
    output logic load_image,
    output logic counter_clr,
    output logic cnn_done
);

    typedef enum logic [2:0] {
        st_idle,
        st_wload,
        st_iload,
        st_drain,
        st_done
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   start_d;
    logic   start_rise;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start_d <= 1'b0;
            state   <= st_idle;
        end else begin
            start_d <= start_cnn;
            state   <= state_nxt;
        end
    end

    assign start_rise = start_cnn & ~start_d;   // only the edge starts a run

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:
                if (start_rise) state_nxt = st_wload;
            st_wload:
                if (weights_full) state_nxt = st_iload;   // 150th bit accepted
            st_iload:
                if (image_last) state_nxt = st_drain;
            st_drain:
                if (drain_done) state_nxt = st_done;
            st_done:
                state_nxt = st_idle;
            default:
                state_nxt = st_idle;
        endcase
    end

    assign load_weights = (state == st_wload);
    assign load_image   = (state == st_iload);

    // one ready per state, never both
    assign weight_tready = load_weights;
    assign image_tready  = load_image;

    // counters restart on the same edge that leaves idle
    assign counter_clr = (state == st_idle) & start_rise;

    assign cnn_done = (state == st_done);

endmodule

`default_nettype wire

// File: cnn_data_pkg.sv
`default_nettype none

package cnn_data_pkg;

    typedef logic signed [15:0] pixel_t;

    // partial row sums and kernel totals
    typedef logic signed [31:0] acc_t;

    typedef logic signed [31:0] result_t;

    // one window row, index 0 is the leftmost column
    typedef pixel_t tap_row_t [cnn_geom_pkg::k_size];

    // one binary kernel, bit t is tap t in row-major order
    typedef logic [cnn_geom_pkg::k_taps-1:0] kernel_t;

endpackage

`default_nettype wire

// File: cnn_geom_pkg.sv
`default_nettype none

package cnn_geom_pkg;

    // input image, streamed row by row
    localparam int img_w = 12;
    localparam int img_h = 12;

    localparam int k_size    = 5;
    localparam int k_taps    = k_size * k_size;
    localparam int n_kernels = 6;

    localparam int n_weight_bits = n_kernels * k_taps;   // 150 per run

    // valid window positions
    localparam int out_w = img_w - k_size + 1;
    localparam int out_h = img_h - k_size + 1;

    // tap register plus two adder stages
    localparam int pipe_depth = 3;

    localparam int col_w  = 4;
    localparam int row_w  = 4;
    localparam int wcnt_w = 8;

endpackage

`default_nettype wire

// File: cnn_top.sv
`timescale 1ns/100ps
`default_nettype none

module cnn_top (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       start_cnn,
    input  wire                       weight_tvalid,
    input  wire                       weight_tdata,
    output logic                      weight_tready,
    input  wire                       image_tvalid,
    input  wire cnn_data_pkg::pixel_t   image_tdata,
    output logic                      image_tready,
    output logic                      result_tvalid,
    output cnn_data_pkg::result_t     result_tdata [cnn_geom_pkg::n_kernels],
    output logic                      cnn_done
);

    logic load_weights;
    logic load_image;
    logic counter_clr;
    logic weights_full;
    logic image_last;
    logic window_ok;
    logic drain_done;
    logic weight_fire;
    logic pixel_fire;
    logic taps_valid;

    cnn_data_pkg::kernel_t  kernels [cnn_geom_pkg::n_kernels];
    cnn_data_pkg::tap_row_t taps    [cnn_geom_pkg::k_size];

    // accepted transfers, ready only ever high in its load phase
    assign weight_fire = weight_tvalid & weight_tready & load_weights;
    assign pixel_fire  = image_tvalid & image_tready;

    cnn_ctrl ctrl_i (
        .clk           (clk),
        .rstn          (rstn),
        .start_cnn     (start_cnn),
        .weights_full  (weights_full),
        .image_last    (image_last),
        .drain_done    (drain_done),
        .weight_tready (weight_tready),
        .image_tready  (image_tready),
        .load_weights  (load_weights),
        .load_image    (load_image),
        .counter_clr   (counter_clr),
        .cnn_done      (cnn_done)
    );

    cnn_counters counters_i (
        .clk          (clk),
        .rstn         (rstn),
        .counter_clr  (counter_clr),
        .weight_fire  (weight_fire),
        .pixel_fire   (pixel_fire),
        .load_image   (load_image),
        .weights_full (weights_full),
        .image_last   (image_last),
        .window_ok    (window_ok),
        .drain_done   (drain_done)
    );

    kernel_store kernel_store_i (
        .clk          (clk),
        .rstn         (rstn),
        .weight_fire  (weight_fire),
        .weight_tdata (weight_tdata),
        .kernels      (kernels)
    );

    line_window line_window_i (
        .clk         (clk),
        .rstn        (rstn),
        .pixel_fire  (pixel_fire),
        .image_tdata (image_tdata),
        .window_ok   (window_ok),
        .taps        (taps),
        .taps_valid  (taps_valid)
    );

    binary_conv binary_conv_i (
        .clk           (clk),
        .rstn          (rstn),
        .taps          (taps),
        .taps_valid    (taps_valid),
        .kernels       (kernels),
        .result_tvalid (result_tvalid),
        .result_tdata  (result_tdata)
    );

endmodule

`default_nettype wire

// File: kernel_store.sv
`timescale 1ns/100ps
`default_nettype none

module kernel_store (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   weight_fire,
    input  wire                   weight_tdata,
    output cnn_data_pkg::kernel_t kernels [cnn_geom_pkg::n_kernels]
);

    logic [cnn_geom_pkg::n_weight_bits-1:0] wbits;

    // new bits enter at the top, so the first bit of a run ends at bit 0
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            wbits <= '0;
        else if (weight_fire)
            wbits <= {weight_tdata, wbits[cnn_geom_pkg::n_weight_bits-1:1]};
    end

    // kernel k owns bits k*25 .. k*25+24
    always_comb begin
        for (int k = 0; k < cnn_geom_pkg::n_kernels; k++) begin
            kernels[k] = wbits[k*cnn_geom_pkg::k_taps +: cnn_geom_pkg::k_taps];
        end
    end

endmodule

`default_nettype wire

// File: line_window.sv
`timescale 1ns/100ps
`default_nettype none

module line_window (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    pixel_fire,
    input  wire cnn_data_pkg::pixel_t image_tdata,
    input  wire                    window_ok,
    output cnn_data_pkg::tap_row_t taps [cnn_geom_pkg::k_size],
    output logic                   taps_valid
);

    localparam int n_lines = cnn_geom_pkg::k_size - 1;

    // line buffer i delays by i+1 image rows
    cnn_data_pkg::pixel_t line_buf [n_lines][cnn_geom_pkg::img_w];
    cnn_data_pkg::pixel_t col_in   [cnn_geom_pkg::k_size];

    always_ff @(posedge clk) begin
        if (pixel_fire) begin
            for (int i = 0; i < n_lines; i++) begin
                for (int j = cnn_geom_pkg::img_w - 1; j > 0; j--) begin
                    line_buf[i][j] <= line_buf[i][j-1];
                end
            end
            line_buf[0][0] <= image_tdata;
            for (int i = 1; i < n_lines; i++) begin
                line_buf[i][0] <= line_buf[i-1][cnn_geom_pkg::img_w-1];
            end
        end
    end

    // newest column, oldest row on top
    always_comb begin
        col_in[cnn_geom_pkg::k_size-1] = image_tdata;
        for (int i = 0; i < n_lines; i++) begin
            col_in[n_lines-1-i] = line_buf[i][cnn_geom_pkg::img_w-1];
        end
    end

    // window slides one column left per accepted pixel
    always_ff @(posedge clk) begin
        if (pixel_fire) begin
            for (int r = 0; r < cnn_geom_pkg::k_size; r++) begin
                for (int c = 0; c < cnn_geom_pkg::k_size - 1; c++) begin
                    taps[r][c] <= taps[r][c+1];
                end
                taps[r][cnn_geom_pkg::k_size-1] <= col_in[r];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            taps_valid <= 1'b0;
        else
            taps_valid <= window_ok;   // already qualified by pixel_fire
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_cnn -o tb_cnn &&
{ ./obj_dir/tb_cnn > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -q '^NO ERRORS$' sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb_cnn.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cnn;

    localparam int n_pixels   = cnn_geom_pkg::img_w * cnn_geom_pkg::img_h;
    localparam int n_windows  = cnn_geom_pkg::out_w * cnn_geom_pkg::out_h;
    localparam int margin     = cnn_geom_pkg::k_size - 1;
    localparam int wait_limit = 2000;   // cycles per wait loop

    logic                  clk;
    logic                  rstn;
    logic                  start_cnn;
    logic                  weight_tvalid;
    logic                  weight_tdata;
    logic                  weight_tready;
    logic                  image_tvalid;
    cnn_data_pkg::pixel_t  image_tdata;
    logic                  image_tready;
    logic                  result_tvalid;
    cnn_data_pkg::result_t result_tdata [cnn_geom_pkg::n_kernels];
    logic                  cnn_done;

    logic [31:0] lfsr;
    logic [15:0] gap;
    int          cyc = 0;
    int          run_idx;
    int          res_count;
    int          done_count;
    int          last_res_cyc;
    int          n_weights;
    int          n_pix;
    int          exp_val;
    int          due_q  [$];
    int          lane_q [$];   // six lanes per window
    bit          wts    [cnn_geom_pkg::n_weight_bits];
    int          img    [cnn_geom_pkg::img_h][cnn_geom_pkg::img_w];

    cnn_top dut_i (
        .clk           (clk),
        .rstn          (rstn),
        .start_cnn     (start_cnn),
        .weight_tvalid (weight_tvalid),
        .weight_tdata  (weight_tdata),
        .weight_tready (weight_tready),
        .image_tvalid  (image_tvalid),
        .image_tdata   (image_tdata),
        .image_tready  (image_tready),
        .result_tvalid (result_tvalid),
        .result_tdata  (result_tdata),
        .cnn_done      (cnn_done)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;   // read at negedges only

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // first bit taken lands in bit 0
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic stop_on_failure(input string what);
        $display("%s at time %0t", what, $time);
        $display("ERRORS FOUND");
        $fatal(1, "stopped on failure");
    endtask

    // +pixel for weight 1, -pixel for weight 0, then relu
    function automatic int window_sum(input int k, input int pr, input int pc);
        int s;
        int p;
        s = 0;
        for (int r = 0; r < cnn_geom_pkg::k_size; r++) begin
            for (int c = 0; c < cnn_geom_pkg::k_size; c++) begin
                p = img[pr - margin + r][pc - margin + c];
                if (wts[k * cnn_geom_pkg::k_taps + r * cnn_geom_pkg::k_size + c])
                    s = s + p;
                else
                    s = s - p;
            end
        end
        return (s < 0) ? 0 : s;
    endfunction

    task automatic accept_pixel();
        int r;
        int c;
        r = n_pix / cnn_geom_pkg::img_w;
        c = n_pix % cnn_geom_pkg::img_w;
        img[r][c] = int'(image_tdata);
        if (r >= margin && c >= margin) begin
            due_q.push_back(cyc + cnn_geom_pkg::pipe_depth);
            for (int k = 0; k < cnn_geom_pkg::n_kernels; k++)
                lane_q.push_back(window_sum(k, r, c));
        end
        n_pix++;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #1;
        res_count  = 0;
        done_count = 0;
        start_cnn  = 1'b1;
        @(negedge clk);
        check_equal(weight_tready, 0, "weight_tready before start edge");
        @(posedge clk);
        #1 start_cnn = 1'b0;
        @(negedge clk);
        check_equal(weight_tready, 1, "weight_tready one cycle after start");
        check_equal(image_tready, 0, "image_tready at start of weight load");
    endtask

    task automatic load_weights();
        int waited;
        waited    = 0;
        n_weights = 0;
        while (n_weights < cnn_geom_pkg::n_weight_bits) begin
            @(posedge clk);
            #1;
            gap           = take_bits(1);
            weight_tvalid = gap[0];
            gap           = take_bits(1);
            weight_tdata  = gap[0];
            @(negedge clk);
            check_equal(image_tready, 0, "image_tready low during weight load");
            if (weight_tvalid && weight_tready) begin
                wts[n_weights] = weight_tdata;
                n_weights++;
            end
            waited++;
            if (waited > wait_limit)
                stop_on_failure("timeout while loading weights");
        end
        @(posedge clk);
        #1 weight_tvalid = 1'b1;   // extra bit, must be refused
        @(negedge clk);
        check_equal(weight_tready, 0, "weight_tready after 150 bits");
        check_equal(image_tready, 1, "image_tready after 150 bits");
    endtask

    task automatic load_image();
        int waited;
        waited = 0;
        n_pix  = 0;
        while (n_pix < n_pixels) begin
            @(posedge clk);
            #1;
            gap          = take_bits(1);
            image_tvalid = gap[0];
            image_tdata  = take_bits(16);
            @(negedge clk);
            check_equal(weight_tready, 0, "weight_tready low during image load");
            if (image_tvalid && image_tready)
                accept_pixel();
            waited++;
            if (waited > wait_limit)
                stop_on_failure("timeout while loading the image");
        end
        @(posedge clk);
        #1 image_tvalid = 1'b1;
        @(negedge clk);
        check_equal(image_tready, 0, "image_tready after 144 pixels");
    endtask

    task automatic finish_run();
        int waited;
        @(posedge clk);
        #1;
        weight_tvalid = 1'b0;
        image_tvalid  = 1'b0;
        waited        = 0;
        while (!cnn_done) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit)
                stop_on_failure("timeout waiting for cnn_done");
        end
        for (int i = 0; i < 4; i++)
            @(negedge clk);
        @(posedge clk);
        #1;
        check_equal(done_count, 1, "cnn_done pulses per run");
        check_equal(res_count, n_windows, "results per run");
        check_equal(due_q.size(), 0, "results still outstanding");
    endtask

    // result and done monitor
    always @(negedge clk) begin
        if (rstn) begin
            if (result_tvalid) begin
                if (due_q.size() == 0)
                    stop_on_failure("result_tvalid high with no window outstanding");
                check_equal(cyc, due_q.pop_front(), "result latency");
                for (int k = 0; k < cnn_geom_pkg::n_kernels; k++) begin
                    exp_val = lane_q.pop_front();
                    check_equal(result_tdata[k], exp_val,
                        $sformatf("run %0d window %0d lane %0d", run_idx, res_count, k));
                end
                res_count++;
                last_res_cyc = cyc;
            end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
                stop_on_failure("result_tvalid missing for an accepted window");
            end
            if (cnn_done) begin
                done_count++;
                check_equal(done_count, 1, "single cnn_done pulse");
                check_equal(cyc, last_res_cyc + 1, "cnn_done one cycle after last result");
                check_equal(res_count, n_windows, "results before cnn_done");
            end
        end
    end

    initial begin
        lfsr          = 32'hc62fd08b;
        last_res_cyc  = 0;
        rstn          = 1'b0;
        start_cnn     = 1'b0;
        weight_tvalid = 1'b0;
        weight_tdata  = 1'b0;
        image_tvalid  = 1'b0;
        image_tdata   = '0;
        repeat (10) @(posedge clk);
        #1 rstn = 1'b1;
        @(negedge clk);
        check_equal(weight_tready, 0, "weight_tready after reset");
        check_equal(image_tready, 0, "image_tready after reset");
        check_equal(result_tvalid, 0, "result_tvalid after reset");
        check_equal(cnn_done, 0, "cnn_done after reset");
        for (run_idx = 0; run_idx < 2; run_idx++) begin
            pulse_start();
            load_weights();
            load_image();
            finish_run();
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
